/* common/profiler_pkg.sv */
// Core profiler package.
// Widths, counter indices and the record types shared by the profiler blocks.

package profiler_pkg;

  localparam int ctr_width_lp   = 32;
  localparam int coord_width_lp = 6;
  localparam int data_width_lp  = 32;
  localparam int addr_width_lp  = 32;
  localparam int num_ctr_lp     = 17;

  // A store to this address asks the tile to dump its statistics.
  localparam logic [addr_width_lp-1:0] print_stat_addr_lp = 32'h0000_1ff0;

  typedef enum logic [4:0] {
    ctr_cycle,
    ctr_instr,
    ctr_fadd,
    ctr_fmul,
    ctr_ld,
    ctr_st,
    ctr_branch,
    ctr_mispredict,
    ctr_st_fp,
    ctr_st_depend,
    ctr_st_ifetch,
    ctr_st_lr_aq,
    ctr_st_fence,
    ctr_st_md,
    ctr_st_force_wb,
    ctr_st_remote_req,
    ctr_st_local_flw
  } ctr_id_e;

  // Decoded instruction sitting in the id stage.
  typedef struct packed {
    logic instr_nonzero;
    logic icache_miss;
    logic is_fp_float_op;
    logic fadd_op;
    logic fmul_op;
    logic is_load_op;
    logic is_store_op;
    logic is_branch_op;
    logic is_jalr_op;
  } commit_s;

  typedef struct packed {
    logic stall;
    logic stall_depend;
    logic stall_fp;
    logic stall_ifetch_wait;
    logic stall_icache_store;
    logic stall_lr_aq;
    logic stall_fence;
    logic stall_md;
    logic stall_force_wb;
    logic stall_remote_req;
    logic stall_local_flw;
  } stall_s;

  typedef struct packed {
    logic [addr_width_lp-1:0] addr;
    logic [data_width_lp-1:0] payload;
  } remote_req_s;

  // Fields run from the highest index down, so bit i is the strobe of counter i.
  typedef struct packed {
    logic st_local_flw;
    logic st_remote_req;
    logic st_force_wb;
    logic st_md;
    logic st_fence;
    logic st_lr_aq;
    logic st_ifetch;
    logic st_depend;
    logic st_fp;
    logic mispredict;
    logic branch;
    logic st;
    logic ld;
    logic fmul;
    logic fadd;
    logic instr;
    logic cycle;
  } event_s;

  typedef logic [num_ctr_lp-1:0][ctr_width_lp-1:0] ctr_array_t;

  typedef struct packed {
    logic [coord_width_lp-1:0] my_x;
    logic [coord_width_lp-1:0] my_y;
    logic [ctr_width_lp-1:0]   global_ctr;
    logic [data_width_lp-1:0]  tag;
    ctr_id_e                   id;
    logic [ctr_width_lp-1:0]   value;
  } dump_rec_s;

endpackage

/* source/event_classifier.sv */
// Event classifier.
// Turns the commit record and the stall flags into registered one-cycle
// increment strobes, one per profiling counter.

`timescale 1ns/1ns

module event_classifier (
  input  logic                   clk_i,
  input  logic                   reset_i,
  input  profiler_pkg::commit_s  commit_i,
  input  profiler_pkg::stall_s   stall_i,
  input  logic                   flush_i,
  input  logic                   branch_mispredict_i,
  input  logic                   jalr_mispredict_i,
  output profiler_pkg::event_s   events_o
);

  import profiler_pkg::*;

  logic   committed;
  logic   other_mem_stall;
  event_s events_next;
  event_s events_r;

  // An instruction retires only when the id stage actually moves.
  assign committed = ~(stall_i.stall | stall_i.stall_depend | flush_i)
                   & commit_i.instr_nonzero
                   & ~commit_i.icache_miss;

  // Any of these stalls takes the blame ahead of a forced writeback.
  assign other_mem_stall = stall_i.stall_ifetch_wait | stall_i.stall_icache_store
                         | stall_i.stall_lr_aq | stall_i.stall_fence
                         | stall_i.stall_md | stall_i.stall_remote_req
                         | stall_i.stall_local_flw;

  always_comb begin
    events_next            = '0;
    events_next.cycle      = 1'b1;
    events_next.instr      = committed;
    events_next.fadd       = committed & commit_i.is_fp_float_op & commit_i.fadd_op;
    events_next.fmul       = committed & commit_i.is_fp_float_op & commit_i.fmul_op;
    events_next.ld         = committed & commit_i.is_load_op;
    events_next.st         = committed & commit_i.is_store_op;
    events_next.branch     = committed & (commit_i.is_branch_op | commit_i.is_jalr_op);
    events_next.mispredict = (branch_mispredict_i | jalr_mispredict_i)
                           & ~(stall_i.stall | stall_i.stall_depend | stall_i.stall_fp);

    events_next.st_depend     = stall_i.stall_depend & ~(stall_i.stall | stall_i.stall_fp);
    events_next.st_fp         = stall_i.stall_fp & ~(stall_i.stall | stall_i.stall_depend);
    events_next.st_force_wb   = stall_i.stall_force_wb & ~other_mem_stall;
    events_next.st_ifetch     = stall_i.stall_ifetch_wait;
    events_next.st_lr_aq      = stall_i.stall_lr_aq;
    events_next.st_fence      = stall_i.stall_fence;
    events_next.st_md         = stall_i.stall_md;
    events_next.st_remote_req = stall_i.stall_remote_req;
    events_next.st_local_flw  = stall_i.stall_local_flw;
  end

  // Registering the strobes keeps the decode off the counter adder path.
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      events_r <= '0;
    end else begin
      events_r <= events_next;
    end
  end

  assign events_o = events_r;

endmodule

/* counter_bank/stat_counter_bank.sv */
// Statistics counter bank.
// Seventeen free-running 32-bit event counters, read out as one packed array.

`timescale 1ns/1ns

module stat_counter_bank (
  input  logic                      clk_i,
  input  logic                      reset_i,
  input  profiler_pkg::event_s      events_i,
  output profiler_pkg::ctr_array_t  counters_o
);

  import profiler_pkg::*;

  logic [num_ctr_lp-1:0] strobe;
  ctr_array_t            counters_r;
  ctr_array_t            counters_inc;

  // Bit i of the event struct belongs to counter i.
  assign strobe = events_i;

  genvar i;
  generate
    for (i = 0; i < num_ctr_lp; i++) begin : g_ctr
      assign counters_inc[i] = counters_r[i] + ctr_width_lp'(1);

      // Counters wrap silently at the top of their range.
      always_ff @(posedge clk_i) begin
        if (reset_i) begin
          counters_r[i] <= '0;
        end else if (strobe[i]) begin
          counters_r[i] <= counters_inc[i];
        end
      end
    end
  endgenerate

  assign counters_o = counters_r;

endmodule

/* source/stat_print_tracker.sv */
// Stat-print tracker.
// Follows an accepted store to the print address through mem and wb,
// holding it while the core stalls, and flags the cycle it retires.

`timescale 1ns/1ns

module stat_print_tracker (
  input  logic                                    clk_i,
  input  logic                                    reset_i,
  input  profiler_pkg::remote_req_s               remote_req_i,
  input  logic                                    remote_req_v_i,
  input  logic                                    remote_req_yumi_i,
  input  logic                                    core_stall_i,
  output logic                                    print_now_o,
  output logic [profiler_pkg::data_width_lp-1:0]  print_tag_o
);

  import profiler_pkg::*;

  logic                     print_exe;
  logic                     print_mem_r;
  logic                     print_wb_r;
  logic [data_width_lp-1:0] tag_mem_r;
  logic [data_width_lp-1:0] tag_wb_r;

  assign print_exe = remote_req_v_i & remote_req_yumi_i
                   & (remote_req_i.addr == print_stat_addr_lp);

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      print_mem_r <= 1'b0;
      print_wb_r  <= 1'b0;
    end else if (~core_stall_i) begin
      print_mem_r <= print_exe;
      print_wb_r  <= print_mem_r;
    end
  end

  // Tags only move alongside a valid print.
  always_ff @(posedge clk_i) begin
    if (~core_stall_i) begin
      if (print_exe) begin
        tag_mem_r <= remote_req_i.payload;
      end
      if (print_mem_r) begin
        tag_wb_r <= tag_mem_r;
      end
    end
  end

  assign print_now_o = print_wb_r & ~core_stall_i;
  assign print_tag_o = tag_wb_r;

endmodule

/* source/stat_dump_serializer.sv */
// Statistics dump serializer.
// Freezes every counter and the tile header on a print, then streams one
// record per cycle for seventeen cycles.

`timescale 1ns/1ns

module stat_dump_serializer (
  input  logic                                     clk_i,
  input  logic                                     reset_i,
  input  logic                                     print_now_i,
  input  logic [profiler_pkg::data_width_lp-1:0]   print_tag_i,
  input  profiler_pkg::ctr_array_t                 counters_i,
  input  logic [profiler_pkg::coord_width_lp-1:0]  my_x_i,
  input  logic [profiler_pkg::coord_width_lp-1:0]  my_y_i,
  input  logic [profiler_pkg::ctr_width_lp-1:0]    global_ctr_i,
  output logic                                     rec_v_o,
  output profiler_pkg::dump_rec_s                  rec_o
);

  import profiler_pkg::*;

  localparam ctr_id_e last_id_lp = ctr_id_e'(num_ctr_lp - 1);

  logic                      busy_r;
  ctr_id_e                   idx_r;
  logic                      capture;

  ctr_array_t                snap_ctr_r;
  logic [coord_width_lp-1:0] snap_x_r;
  logic [coord_width_lp-1:0] snap_y_r;
  logic [ctr_width_lp-1:0]   snap_global_r;
  logic [data_width_lp-1:0]  snap_tag_r;

  // A print that lands during a running dump is dropped.
  assign capture = print_now_i & ~busy_r;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      busy_r <= 1'b0;
      idx_r  <= ctr_cycle;
    end else if (capture) begin
      busy_r <= 1'b1;
      idx_r  <= ctr_cycle;
    end else if (busy_r) begin
      if (idx_r == last_id_lp) begin
        busy_r <= 1'b0;
      end
      idx_r <= ctr_id_e'(idx_r + 5'd1);
    end
  end

  always_ff @(posedge clk_i) begin
    if (capture) begin
      snap_ctr_r    <= counters_i;
      snap_x_r      <= my_x_i;
      snap_y_r      <= my_y_i;
      snap_global_r <= global_ctr_i;
      snap_tag_r    <= print_tag_i;
    end
  end

  always_comb begin
    rec_o.my_x       = snap_x_r;
    rec_o.my_y       = snap_y_r;
    rec_o.global_ctr = snap_global_r;
    rec_o.tag        = snap_tag_r;
    rec_o.id         = idx_r;
    rec_o.value      = snap_ctr_r[idx_r];
  end

  assign rec_v_o = busy_r;

endmodule

/* source/core_profiler.sv */
// Core profiler top level.
// Counts per-cycle core events and dumps the counters on a stat-print store.

`timescale 1ns/1ns

module core_profiler (
  input  logic                                     clk_i,
  input  logic                                     reset_i,
  input  profiler_pkg::commit_s                    commit_i,
  input  profiler_pkg::stall_s                     stall_i,
  input  logic                                     flush_i,
  input  logic                                     branch_mispredict_i,
  input  logic                                     jalr_mispredict_i,
  input  profiler_pkg::remote_req_s                remote_req_i,
  input  logic                                     remote_req_v_i,
  input  logic                                     remote_req_yumi_i,
  input  logic [profiler_pkg::coord_width_lp-1:0]  my_x_i,
  input  logic [profiler_pkg::coord_width_lp-1:0]  my_y_i,
  input  logic [profiler_pkg::ctr_width_lp-1:0]    global_ctr_i,
  output logic                                     rec_v_o,
  output profiler_pkg::dump_rec_s                  rec_o
);

  import profiler_pkg::*;

  event_s                   events;
  ctr_array_t               counters;
  logic                     print_now;
  logic [data_width_lp-1:0] print_tag;

  event_classifier classifier_i (
    .clk_i               (clk_i),
    .reset_i             (reset_i),
    .commit_i            (commit_i),
    .stall_i             (stall_i),
    .flush_i             (flush_i),
    .branch_mispredict_i (branch_mispredict_i),
    .jalr_mispredict_i   (jalr_mispredict_i),
    .events_o            (events)
  );

  stat_counter_bank counter_bank_i (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .events_i   (events),
    .counters_o (counters)
  );

  // The print store advances with the core pipeline, so it sees the main stall.
  stat_print_tracker tracker_i (
    .clk_i             (clk_i),
    .reset_i           (reset_i),
    .remote_req_i      (remote_req_i),
    .remote_req_v_i    (remote_req_v_i),
    .remote_req_yumi_i (remote_req_yumi_i),
    .core_stall_i      (stall_i.stall),
    .print_now_o       (print_now),
    .print_tag_o       (print_tag)
  );

  stat_dump_serializer serializer_i (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .print_now_i  (print_now),
    .print_tag_i  (print_tag),
    .counters_i   (counters),
    .my_x_i       (my_x_i),
    .my_y_i       (my_y_i),
    .global_ctr_i (global_ctr_i),
    .rec_v_o      (rec_v_o),
    .rec_o        (rec_o)
  );

endmodule

/* verification/profiler_model.svh */
// Reference model of the profiler counters and the stat-print pipeline.
// Included into the body of the testbench module.

`ifndef PROFILER_MODEL_SVH
`define PROFILER_MODEL_SVH

localparam logic [4:0] last_idx_lp = 5'(num_ctr_lp - 1);

logic [num_ctr_lp-1:0]    model_events;
ctr_array_t               model_ctr;
logic                     mem_v;
logic                     wb_v;
logic [data_width_lp-1:0] mem_tag;
logic [data_width_lp-1:0] wb_tag;
logic                     model_busy;
logic [4:0]               model_idx;
ctr_array_t               snap_ctr;
logic [coord_width_lp-1:0] snap_x;
logic [coord_width_lp-1:0] snap_y;
logic [ctr_width_lp-1:0]  snap_global;
logic [data_width_lp-1:0] snap_tag;

function automatic logic [num_ctr_lp-1:0] classify_events(input commit_s c, input stall_s s,
                                                          input logic flush,
                                                          input logic br_mis,
                                                          input logic jalr_mis);
  logic [num_ctr_lp-1:0] ev;
  logic                  retire;
  logic                  mem_blame;
  ev = '0;
  retire = !(s.stall || s.stall_depend || flush) && c.instr_nonzero && !c.icache_miss;
  mem_blame = s.stall_ifetch_wait || s.stall_icache_store || s.stall_lr_aq || s.stall_fence
           || s.stall_md || s.stall_remote_req || s.stall_local_flw;
  ev[ctr_cycle]         = 1'b1;
  ev[ctr_instr]         = retire;
  ev[ctr_fadd]          = retire && c.is_fp_float_op && c.fadd_op;
  ev[ctr_fmul]          = retire && c.is_fp_float_op && c.fmul_op;
  ev[ctr_ld]            = retire && c.is_load_op;
  ev[ctr_st]            = retire && c.is_store_op;
  ev[ctr_branch]        = retire && (c.is_branch_op || c.is_jalr_op);
  ev[ctr_mispredict]    = (br_mis || jalr_mis) && !(s.stall || s.stall_depend || s.stall_fp);
  ev[ctr_st_fp]         = s.stall_fp && !s.stall && !s.stall_depend;
  ev[ctr_st_depend]     = s.stall_depend && !s.stall && !s.stall_fp;
  ev[ctr_st_ifetch]     = s.stall_ifetch_wait;
  ev[ctr_st_lr_aq]      = s.stall_lr_aq;
  ev[ctr_st_fence]      = s.stall_fence;
  ev[ctr_st_md]         = s.stall_md;
  ev[ctr_st_force_wb]   = s.stall_force_wb && !mem_blame;
  ev[ctr_st_remote_req] = s.stall_remote_req;
  ev[ctr_st_local_flw]  = s.stall_local_flw;
  return ev;
endfunction

// Called on every rising edge with the inputs that the DUT samples there.
task automatic advance_model();
  logic       print_now;
  logic       print_exe;
  logic [4:0] k;
  if (reset_i) begin
    model_events = '0;
    model_ctr    = '0;
    mem_v        = 1'b0;
    wb_v         = 1'b0;
    model_busy   = 1'b0;
    model_idx    = 5'd0;
  end else begin
    print_now = wb_v && !stall_i.stall;
    // The snapshot takes the counters as they stood before this edge.
    if (print_now && !model_busy) begin
      model_busy  = 1'b1;
      model_idx   = 5'd0;
      snap_ctr    = model_ctr;
      snap_x      = my_x_i;
      snap_y      = my_y_i;
      snap_global = global_ctr_i;
      snap_tag    = wb_tag;
    end else if (model_busy) begin
      if (model_idx == last_idx_lp) begin
        model_busy = 1'b0;
      end
      model_idx = model_idx + 5'd1;
    end
    print_exe = remote_req_v_i && remote_req_yumi_i && (remote_req_i.addr == print_stat_addr_lp);
    if (!stall_i.stall) begin
      if (mem_v) begin
        wb_tag = mem_tag;
      end
      wb_v = mem_v;
      if (print_exe) begin
        mem_tag = remote_req_i.payload;
      end
      mem_v = print_exe;
    end
    for (int i = 0; i < num_ctr_lp; i++) begin
      k = 5'(i);
      if (model_events[k]) begin
        model_ctr[k] = model_ctr[k] + 32'd1;
      end
    end
    model_events = classify_events(commit_i, stall_i, flush_i, branch_mispredict_i,
                                   jalr_mispredict_i);
  end
endtask

`endif

/* verification/core_profiler_tb.sv */
// Core profiler testbench.
// Random core activity with forced stat-print stores, checked against a model.

`timescale 1ns/1ns

module core_profiler_tb;

  import profiler_pkg::*;

  localparam int num_cycles_lp     = 2000;
  localparam int num_dumps_lp      = 5;
  localparam int timeout_cycles_lp = num_cycles_lp + 40 * num_dumps_lp;
  localparam int print_period_lp   = 400;
  localparam int print_offset_lp   = 300;

  logic                      clk_i;
  logic                      reset_i;
  commit_s                   commit_i;
  stall_s                    stall_i;
  logic                      flush_i;
  logic                      branch_mispredict_i;
  logic                      jalr_mispredict_i;
  remote_req_s               remote_req_i;
  logic                      remote_req_v_i;
  logic                      remote_req_yumi_i;
  logic [coord_width_lp-1:0] my_x_i;
  logic [coord_width_lp-1:0] my_y_i;
  logic [ctr_width_lp-1:0]   global_ctr_i;
  logic                      rec_v_o;
  dump_rec_s                 rec_o;

  int   seed;
  int   cycle_count = 0;
  int   check_count = 0;
  int   error_count = 0;
  int   dumps_seen  = 0;
  logic prev_rec_v  = 1'b0;

  `include "profiler_model.svh"

  core_profiler dut_i (
    .clk_i               (clk_i),
    .reset_i             (reset_i),
    .commit_i            (commit_i),
    .stall_i             (stall_i),
    .flush_i             (flush_i),
    .branch_mispredict_i (branch_mispredict_i),
    .jalr_mispredict_i   (jalr_mispredict_i),
    .remote_req_i        (remote_req_i),
    .remote_req_v_i      (remote_req_v_i),
    .remote_req_yumi_i   (remote_req_yumi_i),
    .my_x_i              (my_x_i),
    .my_y_i              (my_y_i),
    .global_ctr_i        (global_ctr_i),
    .rec_v_o             (rec_v_o),
    .rec_o               (rec_o)
  );

  always #2 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    advance_model();
  end

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    check_count++;
    if (actual !== expected) begin
      error_count++;
      $display("** Error: %s is %h, expected %h at %0t ns", name, actual, expected, $time);
    end
  endtask

  task automatic drive_idle_inputs();
    commit_i            = '0;
    stall_i             = '0;
    flush_i             = 1'b0;
    branch_mispredict_i = 1'b0;
    jalr_mispredict_i   = 1'b0;
    remote_req_i        = '0;
    remote_req_v_i      = 1'b0;
    remote_req_yumi_i   = 1'b0;
    my_x_i              = '0;
    my_y_i              = '0;
    global_ctr_i        = '0;
  endtask

  task automatic drive_random_inputs(input int cyc);
    logic [31:0] r0;
    logic [31:0] r1;
    logic [31:0] r2;
    logic [31:0] r3;
    logic [31:0] r4;
    logic [31:0] r5;
    r0 = $random(seed);
    r1 = $random(seed);
    r2 = $random(seed);
    r3 = $random(seed);
    r4 = $random(seed);
    r5 = $random(seed);
    commit_i             = r0[8:0];
    // Two draws ANDed give each stall flag about a one in four chance.
    stall_i              = r1[10:0] & r2[10:0];
    flush_i              = (r0[11:9] == 3'd0);
    branch_mispredict_i  = (r0[13:12] == 2'd0);
    jalr_mispredict_i    = (r0[15:14] == 2'd0);
    my_x_i               = r1[31:26];
    my_y_i               = r2[31:26];
    global_ctr_i         = r5;
    remote_req_v_i       = r3[0];
    remote_req_yumi_i    = r3[1];
    remote_req_i.addr    = r4;
    remote_req_i.payload = r3;
    // A print store that the network has not accepted.
    if (r3[4:2] == 3'd0) begin
      remote_req_i.addr = print_stat_addr_lp;
      remote_req_v_i    = 1'b1;
      remote_req_yumi_i = 1'b0;
    end
    // The second forced store reaches wb while the first dump is streaming.
    if ((cyc % print_period_lp == print_offset_lp)
        || (cyc % print_period_lp == print_offset_lp + 6)) begin
      remote_req_i.addr = print_stat_addr_lp;
      remote_req_v_i    = 1'b1;
      remote_req_yumi_i = 1'b1;
      stall_i.stall     = 1'b0;
    end
  endtask

  task automatic compare_outputs();
    check_value("rec_v_o", {31'd0, rec_v_o}, {31'd0, model_busy});
    if (model_busy) begin
      check_value("rec_o.id", {27'd0, rec_o.id}, {27'd0, model_idx});
      check_value("rec_o.value", rec_o.value, snap_ctr[model_idx]);
      check_value("rec_o.my_x", {26'd0, rec_o.my_x}, {26'd0, snap_x});
      check_value("rec_o.my_y", {26'd0, rec_o.my_y}, {26'd0, snap_y});
      check_value("rec_o.global_ctr", rec_o.global_ctr, snap_global);
      check_value("rec_o.tag", rec_o.tag, snap_tag);
    end
    if (rec_v_o && !prev_rec_v) begin
      dumps_seen++;
    end
    prev_rec_v = rec_v_o;
  endtask

  initial begin
    seed    = 32'hb3fb_193d;
    clk_i   = 1'b0;
    reset_i = 1'b1;
    drive_idle_inputs();
    repeat (3) @(posedge clk_i);
    @(negedge clk_i);
    reset_i = 1'b0;
    for (int cyc = 0; cyc < num_cycles_lp; cyc++) begin
      drive_random_inputs(cyc);
      @(negedge clk_i);
      compare_outputs();
    end
    drive_idle_inputs();
    while (rec_v_o || model_busy) begin
      @(negedge clk_i);
      compare_outputs();
    end
    check_value("dump_count", dumps_seen, num_dumps_lp);
    $display("Checks %0d, errors %0d, dumps %0d", check_count, error_count, dumps_seen);
    if (error_count == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

  always @(posedge clk_i) begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= timeout_cycles_lp) begin
      $display("Timeout: the run did not finish within %0d cycles", timeout_cycles_lp);
      $display("TEST RESULT: FAIL");
      $finish;
    end
  end

endmodule

/* flist.f */
+incdir+verification
common/profiler_pkg.sv
source/event_classifier.sv
counter_bank/stat_counter_bank.sv
source/stat_print_tracker.sv
source/stat_dump_serializer.sv
source/core_profiler.sv
verification/core_profiler_tb.sv

/* Makefile */
SIM  = obj_dir/Vcore_profiler_tb
SRCS = $(filter-out +%,$(shell cat flist.f)) verification/profiler_model.svh

.PHONY: all run clean

all: run

$(SIM): flist.f $(SRCS)
	verilator --binary --timing --top-module core_profiler_tb -f flist.f -o Vcore_profiler_tb

run: $(SIM)
	./$(SIM) > sim.log 2>&1 || true
	cat sim.log
	@if grep -q "TEST RESULT: FAIL" sim.log; then exit 1; fi
	@grep -q "TEST RESULT: PASS" sim.log

clean:
	rm -rf obj_dir sim.log
